// File: Bender.yml
package:
  name: periph_subsystem

sources:
  # Packages first, map before bus types
  - rtl/periph_map_pkg.sv
  - rtl/periph_bus_pkg.sv
  - rtl/obi_req_fifo.sv
  - rtl/obi_reg_bridge.sv
  - rtl/gpio_regs.sv
  - rtl/event_timer.sv
  - rtl/irq_ctrl.sv
  - rtl/periph_subsystem.sv
  - target: test
    files:
      - verification/tb_periph_subsystem.sv

// File: rtl/event_timer.sv
/* 32-bit event timer. Count runs 0..compare then wraps and sets expired.
   Writing compare restarts the count from zero. */
`timescale 1ns/10ps

module event_timer (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  periph_bus_pkg::reg_req_t reg_req_i,
  output periph_bus_pkg::reg_rsp_t reg_rsp_o,
  output logic                     expired_o
);

  periph_bus_pkg::data_t count_q;
  periph_bus_pkg::data_t compare_q;
  logic                  enable_q;
  logic                  expired_q;
  logic                  wr_en;
  logic                  match;

  assign wr_en = reg_req_i.valid && reg_req_i.write;
  assign match = enable_q && (count_q == compare_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q   <= '0;
      compare_q <= '0;
      enable_q  <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_en && reg_req_i.offset == periph_map_pkg::TMR_COMPARE) begin
        compare_q <= reg_req_i.wdata;
        count_q   <= '0;
      end
      if (wr_en && reg_req_i.offset == periph_map_pkg::TMR_CTRL) begin
        enable_q <= reg_req_i.wdata[0];
      end
      // A new match wins over a clear in the same cycle
      if (match) begin
        expired_q <= 1'b1;
      end else if (wr_en && reg_req_i.offset == periph_map_pkg::TMR_EXPIRED &&
                   reg_req_i.wdata[0]) begin
        expired_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (reg_req_i.offset)
      periph_map_pkg::TMR_COUNT:   reg_rsp_o.rdata = count_q;
      periph_map_pkg::TMR_COMPARE: reg_rsp_o.rdata = compare_q;
      periph_map_pkg::TMR_CTRL:    reg_rsp_o.rdata = {31'b0, enable_q};
      periph_map_pkg::TMR_EXPIRED: reg_rsp_o.rdata = {31'b0, expired_q};
      default:                     reg_rsp_o.rdata = '0;
    endcase
  end

  assign expired_o = expired_q;

endmodule

// File: rtl/gpio_regs.sv
/* GPIO with two-flop input sync and rising-edge interrupts.
   GpioWidth must not exceed 32. */
`timescale 1ns/10ps

module gpio_regs #(
  parameter int unsigned GpioWidth = 8
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  periph_bus_pkg::reg_req_t reg_req_i,
  output periph_bus_pkg::reg_rsp_t reg_rsp_o,
  input  logic [GpioWidth-1:0]     gpio_i,
  output logic [GpioWidth-1:0]     gpio_o,
  output logic [GpioWidth-1:0]     gpio_en_o,
  output logic [GpioWidth-1:0]     intr_o
);

  logic [GpioWidth-1:0] sync_q;
  logic [GpioWidth-1:0] gpio_in_q;
  logic [GpioWidth-1:0] gpio_prev_q;
  logic [GpioWidth-1:0] data_out_q;
  logic [GpioWidth-1:0] out_en_q;
  logic [GpioWidth-1:0] intr_state_q;
  logic [GpioWidth-1:0] intr_en_q;
  logic [GpioWidth-1:0] rise;
  logic [GpioWidth-1:0] intr_clr;
  logic [GpioWidth-1:0] wdata;
  logic                 wr_en;

  assign wr_en    = reg_req_i.valid && reg_req_i.write;
  assign wdata    = reg_req_i.wdata[GpioWidth-1:0];
  assign rise     = gpio_in_q & ~gpio_prev_q;
  // W1C on the interrupt state
  assign intr_clr = (wr_en && reg_req_i.offset == periph_map_pkg::GPIO_INTR_STATE) ? wdata : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q       <= '0;
      gpio_in_q    <= '0;
      gpio_prev_q  <= '0;
      data_out_q   <= '0;
      out_en_q     <= '0;
      intr_state_q <= '0;
      intr_en_q    <= '0;
    end else begin
      sync_q       <= gpio_i;
      gpio_in_q    <= sync_q;
      gpio_prev_q  <= gpio_in_q;
      intr_state_q <= (intr_state_q & ~intr_clr) | rise;
      if (wr_en) begin
        case (reg_req_i.offset)
          periph_map_pkg::GPIO_DATA_OUT: data_out_q <= wdata;
          periph_map_pkg::GPIO_OUT_EN:   out_en_q   <= wdata;
          periph_map_pkg::GPIO_INTR_EN:  intr_en_q  <= wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.offset)
      periph_map_pkg::GPIO_DATA_IN:    reg_rsp_o.rdata = 32'(gpio_in_q);
      periph_map_pkg::GPIO_DATA_OUT:   reg_rsp_o.rdata = 32'(data_out_q);
      periph_map_pkg::GPIO_OUT_EN:     reg_rsp_o.rdata = 32'(out_en_q);
      periph_map_pkg::GPIO_INTR_STATE: reg_rsp_o.rdata = 32'(intr_state_q);
      periph_map_pkg::GPIO_INTR_EN:    reg_rsp_o.rdata = 32'(intr_en_q);
      default:                         reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o    = data_out_q;
  assign gpio_en_o = out_en_q;
  assign intr_o    = intr_state_q & intr_en_q;

endmodule

// File: rtl/irq_ctrl.sv
/* Level interrupt controller, lowest pending ID wins.
   Source 0 is never pending; total sources must fit in 32 bits. */
`timescale 1ns/10ps

module irq_ctrl #(
  parameter int unsigned GpioWidth = 8,
  parameter int unsigned NumExtIrq = 4
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  periph_bus_pkg::reg_req_t           reg_req_i,
  output periph_bus_pkg::reg_rsp_t           reg_rsp_o,
  input  logic [GpioWidth+NumExtIrq+1:0]     src_i,
  output logic                               irq_o,
  output periph_map_pkg::irq_id_t            irq_id_o
);

  localparam int unsigned NumSrc = GpioWidth + NumExtIrq + 2;

  logic [NumSrc-1:0]       enable_q;
  logic [NumSrc-1:0]       pending;
  periph_map_pkg::irq_id_t next_id;
  periph_map_pkg::irq_id_t irq_id_q;
  logic                    irq_q;

  assign pending = src_i & enable_q & ~NumSrc'(1);

  // Walk down so the lowest set bit is the last assignment
  always_comb begin
    next_id = '0;
    for (int i = NumSrc - 1; i >= 1; i--) begin
      if (pending[i]) begin
        next_id = periph_map_pkg::irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= '0;
      irq_q    <= 1'b0;
      irq_id_q <= '0;
    end else begin
      irq_q    <= |pending;
      irq_id_q <= next_id;
      if (reg_req_i.valid && reg_req_i.write &&
          reg_req_i.offset == periph_map_pkg::IRQ_ENABLE) begin
        enable_q <= reg_req_i.wdata[NumSrc-1:0];
      end
    end
  end

  always_comb begin
    case (reg_req_i.offset)
      periph_map_pkg::IRQ_PENDING: reg_rsp_o.rdata = 32'(pending);
      periph_map_pkg::IRQ_ENABLE:  reg_rsp_o.rdata = 32'(enable_q);
      periph_map_pkg::IRQ_CLAIM:   reg_rsp_o.rdata = 32'(irq_id_q);
      default:                     reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o    = irq_q;
  assign irq_id_o = irq_id_q;

  assert property (@(posedge clk_i) disable iff (reset_i) irq_o |-> (irq_id_o != '0));

endmodule

// File: rtl/obi_reg_bridge.sv
/* Turns buffered OBI requests into single-cycle register accesses.
   Full-word accesses only; partial byte enables and unmapped selects get err. */
`timescale 1ns/10ps

module obi_reg_bridge (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  periph_bus_pkg::obi_req_t head_i,
  input  logic                     head_valid_i,
  output logic                     pop_o,
  output periph_bus_pkg::obi_rsp_t rsp_o,
  output periph_bus_pkg::reg_req_t gpio_req_o,
  output periph_bus_pkg::reg_req_t timer_req_o,
  output periph_bus_pkg::reg_req_t irq_req_o,
  input  periph_bus_pkg::reg_rsp_t gpio_rsp_i,
  input  periph_bus_pkg::reg_rsp_t timer_rsp_i,
  input  periph_bus_pkg::reg_rsp_t irq_rsp_i
);

  typedef enum logic {
    BR_IDLE,
    BR_ACCESS
  } br_state_e;

  br_state_e                state_q;
  periph_map_pkg::sel_t     head_sel;
  logic                     head_err;
  logic                     acc_valid;
  periph_bus_pkg::data_t    acc_rdata;

  // Registered access, payload only
  logic                     acc_we_q;
  logic                     acc_err_q;
  periph_map_pkg::sel_t     acc_sel_q;
  periph_map_pkg::reg_off_t acc_off_q;
  periph_bus_pkg::data_t    acc_wdata_q;

  logic                     rvalid_q;
  logic                     err_q;
  periph_bus_pkg::data_t    rdata_q;

  assign head_sel = head_i.addr[11:8];
  assign head_err = (head_i.be != '1) ||
                    !(head_sel inside {periph_map_pkg::GPIO_SEL, periph_map_pkg::TIMER_SEL,
                                       periph_map_pkg::IRQ_SEL});

  // Pop also happens in the cycle that carries the previous rvalid
  assign pop_o     = (state_q == BR_IDLE) && head_valid_i;
  assign acc_valid = (state_q == BR_ACCESS) && !acc_err_q;

  assign gpio_req_o  = '{valid: acc_valid && (acc_sel_q == periph_map_pkg::GPIO_SEL),
                         write: acc_we_q, offset: acc_off_q, wdata: acc_wdata_q};
  assign timer_req_o = '{valid: acc_valid && (acc_sel_q == periph_map_pkg::TIMER_SEL),
                         write: acc_we_q, offset: acc_off_q, wdata: acc_wdata_q};
  assign irq_req_o   = '{valid: acc_valid && (acc_sel_q == periph_map_pkg::IRQ_SEL),
                         write: acc_we_q, offset: acc_off_q, wdata: acc_wdata_q};

  always_comb begin
    acc_rdata = periph_map_pkg::ERR_RDATA;
    if (!acc_err_q) begin
      case (acc_sel_q)
        periph_map_pkg::GPIO_SEL:  acc_rdata = gpio_rsp_i.rdata;
        periph_map_pkg::TIMER_SEL: acc_rdata = timer_rsp_i.rdata;
        periph_map_pkg::IRQ_SEL:   acc_rdata = irq_rsp_i.rdata;
        default:                   acc_rdata = periph_map_pkg::ERR_RDATA;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= BR_IDLE;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= pop_o ? BR_ACCESS : BR_IDLE;
      rvalid_q <= (state_q == BR_ACCESS);
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      acc_we_q    <= head_i.we;
      acc_err_q   <= head_err;
      acc_sel_q   <= head_sel;
      acc_off_q   <= head_i.addr[7:0];
      acc_wdata_q <= head_i.wdata;
    end
    if (state_q == BR_ACCESS) begin
      rdata_q <= acc_rdata;
      err_q   <= acc_err_q;
    end
  end

  // gnt comes from the FIFO at the top level
  assign rsp_o = '{gnt: 1'b0, rvalid: rvalid_q, err: err_q, rdata: rdata_q};

  assert property (@(posedge clk_i) disable iff (reset_i) rsp_o.rvalid |=> !rsp_o.rvalid);

endmodule

// File: rtl/obi_req_fifo.sv
/* Request FIFO on the OBI address phase. gnt follows free space, so the
   master may see gnt low for several cycles when the bridge is busy. */
`timescale 1ns/10ps

module obi_req_fifo #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  periph_bus_pkg::obi_req_t req_i,
  output logic                     gnt_o,
  output periph_bus_pkg::obi_req_t head_o,
  output logic                     head_valid_o,
  input  logic                     pop_i
);

  localparam int unsigned PtrW  = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW  = $clog2(FifoDepth + 1);
  localparam int unsigned DataW = $bits(periph_bus_pkg::obi_req_t) - 1;

  // Entry holds everything below the req bit
  logic [DataW-1:0] mem_q [FifoDepth];
  logic [PtrW-1:0]  rd_ptr_q;
  logic [PtrW-1:0]  wr_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             full;
  logic             push;

  assign full         = (count_q == CntW'(FifoDepth));
  assign gnt_o        = !full || pop_i;
  assign push         = req_i.req && gnt_o;
  assign head_valid_o = (count_q != '0);
  assign head_o       = {head_valid_o, mem_q[rd_ptr_q]};

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i[DataW-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Consumer must only pop a valid head
  assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> head_valid_o);

  assert property (@(posedge clk_i) disable iff (reset_i) count_q <= CntW'(FifoDepth));

endmodule

// File: rtl/periph_bus_pkg.sv
/* OBI and register interface types. Needs periph_map_pkg compiled first. */
package periph_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // OBI address phase, 70 bits
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  // OBI grant plus response phase, 35 bits
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;
    data_t rdata;
  } obi_rsp_t;

  // Single-cycle register access, 42 bits
  typedef struct packed {
    logic                     valid;
    logic                     write;
    periph_map_pkg::reg_off_t offset;
    data_t                    wdata;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
  } reg_rsp_t;

endpackage

// File: rtl/periph_map_pkg.sv
/* Peripheral address map. Select is address bits 11:8, offset is bits 7:0.
   Only word-aligned offsets are decoded. */
package periph_map_pkg;

  typedef logic [3:0] sel_t;
  typedef logic [7:0] reg_off_t;
  typedef logic [7:0] irq_id_t;

  // Peripheral selects, anything else is unmapped
  localparam sel_t GPIO_SEL  = 4'd0;
  localparam sel_t TIMER_SEL = 4'd1;
  localparam sel_t IRQ_SEL   = 4'd2;

  // GPIO registers
  localparam reg_off_t GPIO_DATA_IN    = 8'h00;
  localparam reg_off_t GPIO_DATA_OUT   = 8'h04;
  localparam reg_off_t GPIO_OUT_EN     = 8'h08;
  localparam reg_off_t GPIO_INTR_STATE = 8'h0C;
  localparam reg_off_t GPIO_INTR_EN    = 8'h10;

  // Event timer registers
  localparam reg_off_t TMR_COUNT   = 8'h00;
  localparam reg_off_t TMR_COMPARE = 8'h04;
  localparam reg_off_t TMR_CTRL    = 8'h08;
  localparam reg_off_t TMR_EXPIRED = 8'h0C;

  // Interrupt controller registers
  localparam reg_off_t IRQ_PENDING = 8'h00;
  localparam reg_off_t IRQ_ENABLE  = 8'h04;
  localparam reg_off_t IRQ_CLAIM   = 8'h08;

  localparam logic [31:0] ERR_RDATA = 32'h0000_0000;

endpackage

// File: rtl/periph_subsystem.sv
/* Peripheral subsystem behind one OBI slave port. Responses are in order and
   cannot be back-pressured. IDs: 0 unused, GPIO, timer, then external lines. */
`timescale 1ns/10ps

module periph_subsystem #(
  parameter int unsigned GpioWidth = 8,
  parameter int unsigned NumExtIrq = 4,
  parameter int unsigned FifoDepth = 2
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  periph_bus_pkg::obi_req_t slave_req_i,
  output periph_bus_pkg::obi_rsp_t slave_rsp_o,
  input  logic [GpioWidth-1:0]     gpio_i,
  output logic [GpioWidth-1:0]     gpio_o,
  output logic [GpioWidth-1:0]     gpio_en_o,
  input  logic [NumExtIrq-1:0]     intr_ext_i,
  output logic                     irq_o,
  output periph_map_pkg::irq_id_t  irq_id_o,
  output logic                     timer_intr_o
);

  localparam int unsigned NumSrc = GpioWidth + NumExtIrq + 2;

  logic                     fifo_gnt;
  logic                     fifo_head_valid;
  logic                     fifo_pop;
  periph_bus_pkg::obi_req_t fifo_head;
  periph_bus_pkg::obi_rsp_t bridge_rsp;

  periph_bus_pkg::reg_req_t gpio_req;
  periph_bus_pkg::reg_rsp_t gpio_rsp;
  periph_bus_pkg::reg_req_t timer_req;
  periph_bus_pkg::reg_rsp_t timer_rsp;
  periph_bus_pkg::reg_req_t irq_req;
  periph_bus_pkg::reg_rsp_t irq_rsp;

  logic [GpioWidth-1:0]     gpio_intr;
  logic                     timer_expired;
  logic [NumSrc-1:0]        irq_src;

  // ID 0 tied low
  assign irq_src      = {intr_ext_i, timer_expired, gpio_intr, 1'b0};
  assign timer_intr_o = timer_expired;

  assign slave_rsp_o = '{gnt: fifo_gnt, rvalid: bridge_rsp.rvalid, err: bridge_rsp.err,
                         rdata: bridge_rsp.rdata};

  obi_req_fifo #(
    .FifoDepth(FifoDepth)
  ) i_obi_req_fifo (
    .clk_i,
    .reset_i,
    .req_i       (slave_req_i),
    .gnt_o       (fifo_gnt),
    .head_o      (fifo_head),
    .head_valid_o(fifo_head_valid),
    .pop_i       (fifo_pop)
  );

  obi_reg_bridge i_obi_reg_bridge (
    .clk_i,
    .reset_i,
    .head_i      (fifo_head),
    .head_valid_i(fifo_head_valid),
    .pop_o       (fifo_pop),
    .rsp_o       (bridge_rsp),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .irq_req_o   (irq_req),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp),
    .irq_rsp_i   (irq_rsp)
  );

  gpio_regs #(
    .GpioWidth(GpioWidth)
  ) i_gpio_regs (
    .clk_i,
    .reset_i,
    .reg_req_i(gpio_req),
    .reg_rsp_o(gpio_rsp),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_o   (gpio_intr)
  );

  event_timer i_event_timer (
    .clk_i,
    .reset_i,
    .reg_req_i(timer_req),
    .reg_rsp_o(timer_rsp),
    .expired_o(timer_expired)
  );

  irq_ctrl #(
    .GpioWidth(GpioWidth),
    .NumExtIrq(NumExtIrq)
  ) i_irq_ctrl (
    .clk_i,
    .reset_i,
    .reg_req_i(irq_req),
    .reg_rsp_o(irq_rsp),
    .src_i    (irq_src),
    .irq_o,
    .irq_id_o
  );

endmodule

// File: sources.f
rtl/periph_map_pkg.sv
rtl/periph_bus_pkg.sv
rtl/obi_req_fifo.sv
rtl/obi_reg_bridge.sv
rtl/gpio_regs.sv
rtl/event_timer.sv
rtl/irq_ctrl.sv
rtl/periph_subsystem.sv
verification/tb_periph_subsystem.sv

// File: verification/tb_periph_subsystem.sv
/* Directed tests for periph_subsystem at its default parameters
   (8 GPIO pins, 4 external interrupts, FIFO depth 2). */
`timescale 1ns/10ps

module tb_periph_subsystem;

  localparam int GpioW         = 8;
  localparam int NumExt        = 4;
  localparam int TimeoutCycles = 3000;
  // IDs above 0 go to the GPIO pins, then the timer and the external lines
  localparam int TimerId       = GpioW + 1;
  localparam int ExtId0        = GpioW + 2;

  // One outstanding request as the response checker expects it
  typedef struct packed {
    logic        chk;
    logic        err;
    logic [31:0] rdata;
    logic [31:0] acc_cycle;
  } exp_rsp_t;

  logic                     clk = 1'b0;
  logic                     reset_i;
  periph_bus_pkg::obi_req_t slave_req;
  periph_bus_pkg::obi_rsp_t slave_rsp;
  logic [GpioW-1:0]         gpio_i;
  logic [GpioW-1:0]         gpio_o;
  logic [GpioW-1:0]         gpio_en_o;
  logic [NumExt-1:0]        intr_ext_i;
  logic                     irq_o;
  periph_map_pkg::irq_id_t  irq_id_o;
  logic                     timer_intr_o;

  exp_rsp_t                 exp_q[$];
  exp_rsp_t                 mon_exp;
  logic [31:0]              cycle = '0;
  int                       issued = 0;
  int                       returned = 0;
  int                       stall_count = 0;
  int                       error_count = 0;
  periph_bus_pkg::data_t    last_rdata;
  logic [31:0]              last_latency;
  periph_bus_pkg::data_t    gpio_out_model;
  integer                   seed;

  periph_subsystem i_periph_subsystem (
    .clk_i       (clk),
    .reset_i     (reset_i),
    .slave_req_i (slave_req),
    .slave_rsp_o (slave_rsp),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_ext_i  (intr_ext_i),
    .irq_o       (irq_o),
    .irq_id_o    (irq_id_o),
    .timer_intr_o(timer_intr_o)
  );

  always #2 clk = ~clk;

  function automatic periph_bus_pkg::addr_t reg_addr(input periph_map_pkg::sel_t sel,
                                                     input periph_map_pkg::reg_off_t off);
    return {20'h0, sel, off};
  endfunction

  task automatic stop_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic value_error(input string name, input periph_bus_pkg::data_t got,
                             input periph_bus_pkg::data_t exp);
    error_count++;
    $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic plain_error(input string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_eq(input string name, input periph_bus_pkg::data_t got,
                          input periph_bus_pkg::data_t exp);
    assert (got === exp) else value_error(name, got, exp);
  endtask

  // Called right after a clock edge; returns at the edge that accepts the request
  task automatic issue(input logic we, input periph_bus_pkg::addr_t addr,
                       input periph_bus_pkg::be_t be, input periph_bus_pkg::data_t wdata,
                       input logic chk, input logic exp_err,
                       input periph_bus_pkg::data_t exp_rdata);
    exp_rsp_t e;
    slave_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    @(posedge clk);
    while (!slave_rsp.gnt) begin
      stall_count++;
      @(posedge clk);
    end
    e = '{chk: chk, err: exp_err, rdata: exp_rdata, acc_cycle: cycle};
    exp_q.push_back(e);
    issued++;
    slave_req.req <= 1'b0;
  endtask

  task automatic drain();
    while (returned != issued) begin
      @(posedge clk);
    end
  endtask

  task automatic obi_write(input periph_bus_pkg::addr_t addr, input periph_bus_pkg::data_t wdata);
    issue(1'b1, addr, 4'hF, wdata, 1'b0, 1'b0, '0);
    drain();
  endtask

  task automatic obi_read(input periph_bus_pkg::addr_t addr, input periph_bus_pkg::data_t exp);
    issue(1'b0, addr, 4'hF, '0, 1'b1, 1'b0, exp);
    drain();
  endtask

  task automatic read_value(input periph_bus_pkg::addr_t addr,
                            output periph_bus_pkg::data_t val);
    issue(1'b0, addr, 4'hF, '0, 1'b0, 1'b0, '0);
    drain();
    val = last_rdata;
  endtask

  // Responses must match the request order
  always @(posedge clk) begin
    if (!reset_i && slave_rsp.rvalid) begin
      if (exp_q.size() == 0) begin
        plain_error("response arrived with no request outstanding");
      end else begin
        mon_exp = exp_q.pop_front();
        assert (slave_rsp.err === mon_exp.err)
          else value_error("slave_rsp_o.err", slave_rsp.err, mon_exp.err);
        if (mon_exp.chk) begin
          assert (slave_rsp.rdata === mon_exp.rdata)
            else value_error("slave_rsp_o.rdata", slave_rsp.rdata, mon_exp.rdata);
        end
        last_rdata   <= slave_rsp.rdata;
        last_latency <= cycle - mon_exp.acc_cycle;
        returned     <= returned + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      plain_error("tests did not finish within the cycle limit");
    end
  end

  task automatic test_reset_values();
    check_eq("slave_rsp_o.gnt", slave_rsp.gnt, 32'd1);
    check_eq("slave_rsp_o.rvalid", slave_rsp.rvalid, 32'd0);
    check_eq("irq_o", irq_o, 32'd0);
    check_eq("timer_intr_o", timer_intr_o, 32'd0);
    check_eq("gpio_o", gpio_o, 32'd0);
    check_eq("gpio_en_o", gpio_en_o, 32'd0);
  endtask

  task automatic test_gpio();
    periph_bus_pkg::data_t v_out;
    periph_bus_pkg::data_t v_en;
    logic [GpioW-1:0]      pins;
    v_out = $random(seed) & 32'hFF;
    v_en  = $random(seed) & 32'hFF;
    obi_write(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_DATA_OUT), v_out);
    gpio_out_model = v_out;
    obi_write(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_OUT_EN), v_en);
    check_eq("gpio_o", gpio_o, v_out);
    check_eq("gpio_en_o", gpio_en_o, v_en);
    obi_read(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_DATA_OUT), v_out);
    obi_read(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_OUT_EN), v_en);
    pins = $random(seed);
    gpio_i <= pins;
    repeat (4) @(posedge clk);
    obi_read(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_DATA_IN), pins);
    // Start from a clean interrupt state with pin 0 low
    gpio_i <= '0;
    repeat (4) @(posedge clk);
    obi_write(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_INTR_STATE), 32'hFF);
    obi_write(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_INTR_EN), 32'h01);
    obi_read(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_INTR_STATE), 32'h0);
    gpio_i <= 8'h01;
    repeat (5) @(posedge clk);
    obi_read(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_INTR_STATE), 32'h01);
    obi_write(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_INTR_STATE), 32'h01);
    obi_read(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_INTR_STATE), 32'h0);
  endtask

  task automatic test_timer();
    periph_bus_pkg::data_t count;
    int                    n;
    obi_write(reg_addr(periph_map_pkg::TIMER_SEL, periph_map_pkg::TMR_COMPARE), 32'd40);
    obi_write(reg_addr(periph_map_pkg::TIMER_SEL, periph_map_pkg::TMR_CTRL), 32'd1);
    n = 0;
    while (!timer_intr_o && n < 160) begin
      @(posedge clk);
      n++;
    end
    assert (timer_intr_o) else plain_error("timer did not expire within 160 cycles");
    // Count wrapped only a few cycles before this read
    read_value(reg_addr(periph_map_pkg::TIMER_SEL, periph_map_pkg::TMR_COUNT), count);
    assert (count < 32'd40) else value_error("TMR_COUNT upper bound", count, 32'd40);
    obi_write(reg_addr(periph_map_pkg::TIMER_SEL, periph_map_pkg::TMR_CTRL), 32'd0);
    obi_write(reg_addr(periph_map_pkg::TIMER_SEL, periph_map_pkg::TMR_EXPIRED), 32'd1);
    check_eq("timer_intr_o", timer_intr_o, 32'd0);
    obi_read(reg_addr(periph_map_pkg::TIMER_SEL, periph_map_pkg::TMR_EXPIRED), 32'd0);
  endtask

  task automatic test_irq();
    logic [31:0] en_mask;
    int          n;
    en_mask = 32'h1 << TimerId;
    for (int k = 0; k < NumExt; k++) begin
      en_mask = en_mask | (32'h1 << (ExtId0 + k));
    end
    obi_write(reg_addr(periph_map_pkg::IRQ_SEL, periph_map_pkg::IRQ_ENABLE), en_mask);
    intr_ext_i <= 4'b0101;
    n = 0;
    while (!irq_o && n < 20) begin
      @(posedge clk);
      n++;
    end
    assert (irq_o) else plain_error("irq_o did not rise for the external lines");
    check_eq("irq_id_o", irq_id_o, ExtId0);
    obi_read(reg_addr(periph_map_pkg::IRQ_SEL, periph_map_pkg::IRQ_CLAIM), ExtId0);
    obi_write(reg_addr(periph_map_pkg::IRQ_SEL, periph_map_pkg::IRQ_ENABLE),
              en_mask & ~(32'h1 << ExtId0));
    obi_read(reg_addr(periph_map_pkg::IRQ_SEL, periph_map_pkg::IRQ_CLAIM), ExtId0 + 2);
    check_eq("irq_id_o", irq_id_o, ExtId0 + 2);
    intr_ext_i <= '0;
    n = 0;
    while (irq_o && n < 20) begin
      @(posedge clk);
      n++;
    end
    assert (!irq_o) else plain_error("irq_o stayed high after all sources were released");
    obi_read(reg_addr(periph_map_pkg::IRQ_SEL, periph_map_pkg::IRQ_PENDING), 32'd0);
  endtask

  task automatic test_latency_burst();
    periph_bus_pkg::data_t v_out;
    periph_bus_pkg::data_t v_en;
    periph_bus_pkg::data_t v_cmp;
    obi_read(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_DATA_OUT), gpio_out_model);
    check_eq("rvalid latency", last_latency, 32'd3);
    v_out = $random(seed) & 32'hFF;
    v_en  = $random(seed) & 32'hFF;
    v_cmp = $random(seed);
    stall_count = 0;
    // The first four requests fit without a stall and the fifth waits for gnt
    issue(1'b1, reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_DATA_OUT), 4'hF,
          v_out, 1'b0, 1'b0, '0);
    issue(1'b1, reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_OUT_EN), 4'hF,
          v_en, 1'b0, 1'b0, '0);
    issue(1'b1, reg_addr(periph_map_pkg::TIMER_SEL, periph_map_pkg::TMR_COMPARE), 4'hF,
          v_cmp, 1'b0, 1'b0, '0);
    issue(1'b0, reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_DATA_OUT), 4'hF,
          '0, 1'b1, 1'b0, v_out);
    issue(1'b0, reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_OUT_EN), 4'hF,
          '0, 1'b1, 1'b0, v_en);
    issue(1'b0, reg_addr(periph_map_pkg::TIMER_SEL, periph_map_pkg::TMR_COMPARE), 4'hF,
          '0, 1'b1, 1'b0, v_cmp);
    drain();
    gpio_out_model = v_out;
    assert (stall_count > 0) else plain_error("gnt never dropped during the request burst");
  endtask

  task automatic test_errors();
    issue(1'b1, reg_addr(4'h3, 8'h00), 4'hF, 32'hDEAD_BEEF, 1'b1, 1'b1, 32'h0);
    issue(1'b0, reg_addr(4'hF, periph_map_pkg::GPIO_DATA_OUT), 4'hF, '0, 1'b1, 1'b1, 32'h0);
    issue(1'b1, reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_DATA_OUT), 4'b0011,
          ~gpio_out_model, 1'b1, 1'b1, 32'h0);
    drain();
    obi_read(reg_addr(periph_map_pkg::GPIO_SEL, periph_map_pkg::GPIO_DATA_OUT), gpio_out_model);
    check_eq("gpio_o", gpio_o, gpio_out_model);
  endtask

  initial begin
    seed           = 8540;
    reset_i        = 1'b1;
    slave_req      = '0;
    gpio_i         = '0;
    intr_ext_i     = '0;
    gpio_out_model = '0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    @(posedge clk);
    test_reset_values();
    test_gpio();
    test_timer();
    test_irq();
    test_latency_burst();
    test_errors();
    if (error_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule
